// File: Bender.yml
package:
  name: i2c_init

sources:
  - include_dirs:
      - common
    files:
      - common/i2c_init_pkg.sv
      - hdl/i2c_out_stage.sv
      - i2c_init/init_table_rom.sv
      - i2c_init/init_sequencer.sv
      - i2c_init/i2c_init.sv
  - target: simulation
    files:
      - dv/tb_clock_gen.sv
      - dv/i2c_init_asserts.sv
      - dv/tb_i2c_init.sv

// File: common/i2c_init_pkg.sv
// i2c init sequencer shared types, table word encodings and opcodes
package i2c_init_pkg;

    // table geometry
    localparam int init_table_len = 22;
    localparam int table_addr_w = $clog2(init_table_len);

    typedef logic [table_addr_w-1:0] table_addr_t;
    typedef logic [6:0] i2c_addr_t;
    typedef logic [7:0] tx_byte_t;

    // control view prefixes
    localparam logic [1:0] pfx_ctrl = 2'b00;
    localparam logic [1:0] pfx_start_addr = 2'b01;

    // opcodes, only valid under pfx_ctrl
    localparam logic [6:0] op_halt = 7'h00;
    localparam logic [6:0] op_exit_multi = 7'h01;
    localparam logic [6:0] op_start_cur = 7'h03;
    localparam logic [6:0] op_addr_block = 7'h08;
    localparam logic [6:0] op_data_block = 7'h09;
    localparam logic [6:0] op_send_stop = 7'h41;

    // write data entry, msb set
    typedef struct packed {
        logic     wr;
        tx_byte_t data;
    } init_data_view_t;

    // control entry, field is a device address or an opcode
    typedef struct packed {
        logic [1:0] prefix;
        logic [6:0] field;
    } init_ctrl_view_t;

    typedef union packed {
        init_data_view_t data;
        init_ctrl_view_t ctrl;
    } init_word_u;

    // command word as seen by the I2C master, stop in bit 11
    typedef struct packed {
        logic      stop;
        logic      write_multi;
        logic      write;
        logic      read;
        logic      start;
        i2c_addr_t address;
    } i2c_cmd_t;

    // sequencer to output stage
    typedef struct packed {
        i2c_cmd_t cmd;
        logic     cmd_load;
        tx_byte_t tx;
        logic     tx_load;
    } seq_out_t;

endpackage

// File: common/init_table.svh
// i2c init command table, single device write then the same block over four devices
`ifndef INIT_TABLE_SVH
`define INIT_TABLE_SVH

localparam init_word_u init_table [init_table_len] = '{
    // device 0x50, register 0x0004, data 0x11223344
    {pfx_start_addr, 7'h50},
    {1'b1, 8'h00},
    {1'b1, 8'h04},
    {1'b1, 8'h11},
    {1'b1, 8'h22},
    {1'b1, 8'h33},
    {1'b1, 8'h44},
    // same write as a data block
    {pfx_ctrl, op_data_block},
    {pfx_ctrl, op_start_cur},
    {1'b1, 8'h00},
    {1'b1, 8'h04},
    {1'b1, 8'h11},
    {1'b1, 8'h22},
    {1'b1, 8'h33},
    {1'b1, 8'h44},
    // devices the block is applied to
    {pfx_ctrl, op_addr_block},
    {pfx_start_addr, 7'h50},
    {pfx_start_addr, 7'h51},
    {pfx_start_addr, 7'h52},
    {pfx_start_addr, 7'h53},
    {pfx_ctrl, op_exit_multi},
    {pfx_ctrl, op_halt}
};

`endif

// File: compile.f
+incdir+common
common/i2c_init_pkg.sv
hdl/i2c_out_stage.sv
i2c_init/init_table_rom.sv
i2c_init/init_sequencer.sv
i2c_init/i2c_init.sv
dv/tb_clock_gen.sv
dv/i2c_init_asserts.sv
dv/tb_i2c_init.sv

// File: dv/i2c_init_asserts.sv
// output stage checks, stream stability under back-pressure and reset values
module i2c_init_asserts (
    input logic                   clk,
    input logic                   rst,
    input i2c_init_pkg::i2c_cmd_t cmd,
    input logic                   cmd_valid,
    input logic                   cmd_ready,
    input i2c_init_pkg::tx_byte_t tx_data,
    input logic                   tx_valid,
    input logic                   tx_ready
);
    import i2c_init_pkg::*;

    // read back by the testbench top
    int fails = 0;

    // a stalled command word must not move
    cmd_hold: assert property (@(posedge clk) disable iff (rst)
        cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd))
    else begin
        $error("command word or valid changed while cmd_ready was low");
        fails++;
    end

    tx_hold: assert property (@(posedge clk) disable iff (rst)
        tx_valid && !tx_ready |=> tx_valid && $stable(tx_data))
    else begin
        $error("transmit byte or valid changed while tx_ready was low");
        fails++;
    end

    // both streams empty right after a reset edge
    reset_clear: assert property (@(posedge clk)
        rst |=> !cmd_valid && !tx_valid)
    else begin
        $error("output valid still set after reset");
        fails++;
    end

endmodule

// File: dv/init_cases.txt
# cmd values are hex {stop, write_multi, write, read, start, address[6:0]}, tx values are hex bytes
# test lines: name, ready mode (0 always, 1 random), start mode (0 none, 1 pulse, 2 hold), runs
# one full table run, single device write to 0x50
cmd 2d0 250 250 250 250 250
tx  00 04 11 22 33 44
# data block applied to devices 0x50 to 0x53
cmd 2d0 250 250 250 250 250
tx  00 04 11 22 33 44
cmd 2d1 251 251 251 251 251
tx  00 04 11 22 33 44
cmd 2d2 252 252 252 252 252
tx  00 04 11 22 33 44
cmd 2d3 253 253 253 253 253
tx  00 04 11 22 33 44
# stop at halt, still addressed to the last device
cmd 853
# tests
test idle_after_reset 0 0 0
test full_run_ready 0 1 1
test full_run_backpressure 1 1 1
test start_held 0 2 1
test rerun_after_release 1 1 1

// File: dv/tb_clock_gen.sv
// testbench clock source, free running with a period of 100
module tb_clock_gen (
    output logic clk
);

    localparam int half_period = 50;

    initial begin
        clk = 1'b0;
        forever begin
            #(half_period) clk = ~clk;
        end
    end

endmodule

// File: dv/tb_i2c_init.sv
// testbench for the i2c init sequencer, replays the cases file and checks both streams
module tb_i2c_init;
    import i2c_init_pkg::*;

    logic     clk;
    logic     rst;
    logic     start;
    i2c_cmd_t cmd;
    logic     cmd_valid;
    logic     cmd_ready;
    tx_byte_t tx_data;
    logic     tx_valid;
    logic     tx_ready;
    logic     busy;

    // one full table run as read from the cases file
    logic [11:0] exp_cmd [$];
    logic [7:0]  exp_tx [$];
    logic [11:0] got_cmd [$];
    logic [7:0]  got_tx [$];
    string       test_name [$];
    int          test_ready [$];
    int          test_start [$];
    int          test_runs [$];

    logic [31:0] lcg_state;
    logic        random_ready;
    int          errors;
    int          n_pass;
    int          n_fail;
    int          watchdog_cycles;

    tb_clock_gen i_clk (
        .clk (clk)
    );

    i2c_init i_dut (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .tx_data   (tx_data),
        .tx_valid  (tx_valid),
        .tx_ready  (tx_ready),
        .busy      (busy)
    );

    bind i2c_out_stage i2c_init_asserts i_asserts (
        .clk       (clk),
        .rst       (rst),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .tx_data   (tx_data),
        .tx_valid  (tx_valid),
        .tx_ready  (tx_ready)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERR %0t %s expected %0h got %0h", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic read_cases();
        int          fd;
        int          mode;
        string       tok;
        string       line;
        string       name;
        int          r;
        int          s;
        int          n;
        logic [31:0] v;
        mode = 0;
        fd = $fopen("dv/init_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open the cases file dv/init_cases.txt");
            errors++;
            return;
        end
        while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok.substr(0, 0) == "#") begin
                void'($fgets(line, fd));
            end else if (tok == "cmd") begin
                mode = 1;
            end else if (tok == "tx") begin
                mode = 2;
            end else if (tok == "test") begin
                mode = 0;
                void'($fscanf(fd, "%s %d %d %d", name, r, s, n));
                test_name.push_back(name);
                test_ready.push_back(r);
                test_start.push_back(s);
                test_runs.push_back(n);
            end else begin
                void'($sscanf(tok, "%h", v));
                if (mode == 1) begin
                    exp_cmd.push_back(v[11:0]);
                end else if (mode == 2) begin
                    exp_tx.push_back(v[7:0]);
                end
            end
        end
        $fclose(fd);
    endtask

    // ready lines, either held high or toggled from the lcg
    always @(negedge clk) begin
        if (random_ready) begin
            lcg_state = lcg_next(lcg_state);
            cmd_ready = lcg_state[16];
            tx_ready  = lcg_state[23];
        end else begin
            cmd_ready = 1'b1;
            tx_ready  = 1'b1;
        end
    end

    // accepted transfers, busy must still be high for every command before the stop
    always @(posedge clk) begin
        if (!rst && cmd_valid && cmd_ready) begin
            got_cmd.push_back(cmd);
            if (!cmd.stop) begin
                check("busy", 1, busy);
            end
        end
        if (!rst && tx_valid && tx_ready) begin
            got_tx.push_back(tx_data);
        end
    end

    task automatic run_test(input int idx);
        int errs_before;
        int n_cmd;
        int n_tx;
        errs_before = errors;
        n_cmd = test_runs[idx] * exp_cmd.size();
        n_tx = test_runs[idx] * exp_tx.size();
        // ready mode changes between falling edges
        @(posedge clk);
        random_ready = test_ready[idx] != 0;
        @(negedge clk);
        got_cmd.delete();
        got_tx.delete();
        if (test_start[idx] == 0) begin
            repeat (20) begin
                @(negedge clk);
                check("cmd_valid", 0, cmd_valid);
                check("tx_valid", 0, tx_valid);
                check("busy", 0, busy);
            end
        end else begin
            start = 1'b1;
            @(negedge clk);
            if (test_start[idx] == 1) begin
                start = 1'b0;
            end
            repeat (2) @(negedge clk);
            check("busy", 1, busy);
            while (got_cmd.size() < n_cmd || got_tx.size() < n_tx) begin
                @(negedge clk);
            end
            // linger to catch extra transfers, longer while start stays high
            repeat (test_start[idx] == 2 ? 40 : 8) @(negedge clk);
            check("busy", 0, busy);
            start = 1'b0;
            repeat (2) @(negedge clk);
        end
        check("cmd count", n_cmd, got_cmd.size());
        check("tx count", n_tx, got_tx.size());
        for (int k = 0; k < n_cmd && k < got_cmd.size(); k++) begin
            check($sformatf("cmd[%0d]", k), exp_cmd[k % exp_cmd.size()], got_cmd[k]);
        end
        for (int k = 0; k < n_tx && k < got_tx.size(); k++) begin
            check($sformatf("tx_data[%0d]", k), exp_tx[k % exp_tx.size()], got_tx[k]);
        end
        if (errors == errs_before) begin
            n_pass++;
            $display("test %s: pass", test_name[idx]);
        end else begin
            n_fail++;
            $display("test %s: FAIL with %0d errors", test_name[idx], errors - errs_before);
        end
    endtask

    initial begin
        wait (watchdog_cycles != 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", watchdog_cycles);
        $display("Checks failed");
        $finish;
    end

    initial begin
        rst = 1'b1;
        start = 1'b0;
        cmd_ready = 1'b0;
        tx_ready = 1'b0;
        random_ready = 1'b0;
        lcg_state = 32'h502a_39be;
        errors = 0;
        n_pass = 0;
        n_fail = 0;
        watchdog_cycles = 0;
        read_cases();
        // 64 cycles per expected transfer plus the fixed waits of each test
        watchdog_cycles = 200 + 100 * test_name.size();
        foreach (test_runs[i]) begin
            watchdog_cycles += 64 * test_runs[i] * (exp_cmd.size() + exp_tx.size());
        end
        repeat (5) @(negedge clk);
        rst = 1'b0;
        foreach (test_name[i]) begin
            run_test(i);
        end
        if (i_dut.i_out.i_asserts.fails != 0) begin
            $display("%0d assertion failures on the output streams",
                     i_dut.i_out.i_asserts.fails);
            errors += i_dut.i_out.i_asserts.fails;
        end
        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 test_name.size(), n_pass, n_fail, errors);
        if (errors == 0 && n_fail == 0 && test_name.size() != 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: hdl/i2c_out_stage.sv
// i2c output stage, holds command and transmit words until each stream accepts them
module i2c_out_stage (
    input  logic                   clk,
    input  logic                   rst,
    input  i2c_init_pkg::seq_out_t load,
    output i2c_init_pkg::i2c_cmd_t cmd,
    output logic                   cmd_valid,
    input  logic                   cmd_ready,
    output i2c_init_pkg::tx_byte_t tx_data,
    output logic                   tx_valid,
    input  logic                   tx_ready,
    output logic                   out_busy
);

    // command stream
    always_ff @(posedge clk) begin
        if (rst) begin
            cmd_valid <= 1'b0;
        end else if (load.cmd_load) begin
            cmd_valid <= 1'b1;
        end else if (cmd_ready) begin
            cmd_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load.cmd_load) begin
            cmd <= load.cmd;
        end
    end

    // transmit stream
    always_ff @(posedge clk) begin
        if (rst) begin
            tx_valid <= 1'b0;
        end else if (load.tx_load) begin
            tx_valid <= 1'b1;
        end else if (tx_ready) begin
            tx_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load.tx_load) begin
            tx_data <= load.tx;
        end
    end

    // sequencer waits until both streams are empty
    assign out_busy = cmd_valid || tx_valid;

endmodule

// File: i2c_init/i2c_init.sv
// i2c init top, table fetch feeding the sequencer feeding the output registers
module i2c_init (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    output i2c_init_pkg::i2c_cmd_t cmd,
    output logic                   cmd_valid,
    input  logic                   cmd_ready,
    output i2c_init_pkg::tx_byte_t tx_data,
    output logic                   tx_valid,
    input  logic                   tx_ready,
    output logic                   busy
);
    import i2c_init_pkg::*;

    table_addr_t next_addr;
    init_word_u  word;
    seq_out_t    load;
    logic        out_busy;

    init_table_rom i_rom (
        .clk       (clk),
        .rst       (rst),
        .next_addr (next_addr),
        .word      (word)
    );

    init_sequencer i_seq (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .word      (word),
        .out_busy  (out_busy),
        .next_addr (next_addr),
        .load      (load),
        .busy      (busy)
    );

    i2c_out_stage i_out (
        .clk       (clk),
        .rst       (rst),
        .load      (load),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .tx_data   (tx_data),
        .tx_valid  (tx_valid),
        .tx_ready  (tx_ready),
        .out_busy  (out_busy)
    );

endmodule

// File: i2c_init/init_sequencer.sv
// init sequencer, walks the command table and drives the single and multi device modes
module init_sequencer (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      start,
    input  i2c_init_pkg::init_word_u  word,
    input  logic                      out_busy,
    output i2c_init_pkg::table_addr_t next_addr,
    output i2c_init_pkg::seq_out_t    load,
    output logic                      busy
);
    import i2c_init_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_run,
        st_find_addr_blk,
        st_next_address,
        st_data_blk
    } state_t;

    state_t      state, state_next;
    table_addr_t tbl_addr, tbl_addr_next;
    table_addr_t tbl_addr_inc;
    table_addr_t data_ptr, data_ptr_next;
    table_addr_t addr_ptr, addr_ptr_next;
    i2c_addr_t   cur_dev, cur_dev_next;
    i2c_addr_t   pend_addr, pend_addr_next;
    logic        pend_start, pend_start_next;
    logic        start_latch, start_latch_next;
    logic        emit_write;
    logic        emit_stop;

    // decoded table word
    logic is_write;
    logic is_start_addr;
    logic is_ctrl;
    logic is_halt;
    logic is_exit;
    logic is_start_cur;
    logic is_addr_blk;
    logic is_data_blk;
    logic is_send_stop;

    assign is_write      = word.data.wr;
    assign is_start_addr = word.ctrl.prefix == pfx_start_addr;
    assign is_ctrl       = word.ctrl.prefix == pfx_ctrl;
    assign is_halt       = is_ctrl && word.ctrl.field == op_halt;
    assign is_exit       = is_ctrl && word.ctrl.field == op_exit_multi;
    assign is_start_cur  = is_ctrl && word.ctrl.field == op_start_cur;
    assign is_addr_blk   = is_ctrl && word.ctrl.field == op_addr_block;
    assign is_data_blk   = is_ctrl && word.ctrl.field == op_data_block;
    assign is_send_stop  = is_ctrl && word.ctrl.field == op_send_stop;

    assign tbl_addr_inc = tbl_addr + 1'b1;
    assign next_addr    = tbl_addr_next;

    always_comb begin
        state_next       = state;
        tbl_addr_next    = tbl_addr;
        data_ptr_next    = data_ptr;
        addr_ptr_next    = addr_ptr;
        cur_dev_next     = cur_dev;
        pend_addr_next   = pend_addr;
        pend_start_next  = pend_start;
        start_latch_next = start_latch;
        emit_write       = 1'b0;
        emit_stop        = 1'b0;

        // hold everything until both output registers have drained
        if (!out_busy) begin
            if (state != st_idle && is_halt) begin
                // halt stays on its own entry
                emit_stop  = 1'b1;
                state_next = st_idle;
            end else begin
                case (state)
                    st_idle: begin
                        if (start && !start_latch) begin
                            tbl_addr_next    = '0;
                            start_latch_next = 1'b1;
                            state_next       = st_run;
                        end
                    end
                    st_run, st_data_blk: begin
                        // unlisted codes just step over
                        tbl_addr_next = tbl_addr_inc;
                        if (is_write) begin
                            emit_write = 1'b1;
                        end else if (is_start_addr) begin
                            pend_addr_next  = word.ctrl.field;
                            pend_start_next = 1'b1;
                        end else if (is_send_stop) begin
                            emit_stop = 1'b1;
                        end else if (is_data_blk) begin
                            data_ptr_next = tbl_addr_inc;
                            state_next    = st_find_addr_blk;
                        end else if (state == st_data_blk) begin
                            // codes that only mean something inside a data block
                            if (is_start_cur) begin
                                pend_addr_next  = cur_dev;
                                pend_start_next = 1'b1;
                            end else if (is_addr_blk) begin
                                // block done, go fetch the next device
                                tbl_addr_next = addr_ptr;
                                state_next    = st_next_address;
                            end else if (is_exit) begin
                                state_next = st_run;
                            end
                        end
                    end
                    st_find_addr_blk: begin
                        tbl_addr_next = tbl_addr_inc;
                        if (is_addr_blk) begin
                            addr_ptr_next = tbl_addr_inc;
                            state_next    = st_next_address;
                        end else if (is_data_blk) begin
                            data_ptr_next = tbl_addr_inc;
                        end else if (is_exit) begin
                            state_next = st_run;
                        end
                    end
                    st_next_address: begin
                        tbl_addr_next = tbl_addr_inc;
                        if (is_start_addr) begin
                            // remember device, jump back to the top of the data block
                            cur_dev_next  = word.ctrl.field;
                            addr_ptr_next = tbl_addr_inc;
                            tbl_addr_next = data_ptr;
                            state_next    = st_data_blk;
                        end else if (is_data_blk) begin
                            data_ptr_next = tbl_addr_inc;
                            state_next    = st_find_addr_blk;
                        end else if (is_exit) begin
                            state_next = st_run;
                        end
                    end
                    default: begin
                        state_next = st_idle;
                    end
                endcase
            end
        end

        // start goes out with the first command after a start word only
        if (emit_write || emit_stop) begin
            pend_start_next = 1'b0;
        end
    end

    always_comb begin
        load             = '0;
        load.cmd.address = pend_addr;
        load.cmd.start   = emit_write && pend_start;
        load.cmd.write   = emit_write;
        load.cmd.stop    = emit_stop;
        load.cmd_load    = emit_write || emit_stop;
        load.tx          = word.data.data;
        load.tx_load     = emit_write;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= st_idle;
            tbl_addr    <= '0;
            data_ptr    <= '0;
            addr_ptr    <= '0;
            pend_start  <= 1'b0;
            start_latch <= 1'b0;
            busy        <= 1'b0;
        end else begin
            state       <= state_next;
            tbl_addr    <= tbl_addr_next;
            data_ptr    <= data_ptr_next;
            addr_ptr    <= addr_ptr_next;
            pend_start  <= pend_start_next;
            // latch releases as soon as start drops
            start_latch <= start && start_latch_next;
            busy        <= state != st_idle;
        end
    end

    always_ff @(posedge clk) begin
        cur_dev   <= cur_dev_next;
        pend_addr <= pend_addr_next;
    end

endmodule

// File: i2c_init/init_table_rom.sv
// init table ROM, registers the entry selected by the next table address
module init_table_rom (
    input  logic                      clk,
    input  logic                      rst,
    input  i2c_init_pkg::table_addr_t next_addr,
    output i2c_init_pkg::init_word_u  word
);
    import i2c_init_pkg::*;

    `include "init_table.svh"

    // addresses past the end read back as halt
    always_ff @(posedge clk) begin
        if (rst) begin
            word <= '0;
        end else if (next_addr < table_addr_t'(init_table_len)) begin
            word <= init_table[next_addr];
        end else begin
            word <= {pfx_ctrl, op_halt};
        end
    end

endmodule
